// File: flist.f
fifo_pkg.sv
cdc_pkg.sv
drsync.sv
fifo_ptr.sv
fifo_ram.sv
chaos_lfsr.sv
asyncfifo.sv
fifo_checker.sv
tb_asyncfifo.sv

// File: run_sim.sh
#!/bin/sh
# Builds the FIFO testbench with Verilator and runs it
# Exit status is nonzero when the build breaks or the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
   --top-module tb_asyncfifo -f flist.f > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_asyncfifo > sim.log 2>&1 ; cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }

// File: tb_asyncfifo.sv
// Testbench for the dual clock FIFO with unrelated clocks and fixed seed LFSR traffic
// Drives and sequences only while fifo_checker does all the comparing
`timescale 1ns/100ps

module tb_asyncfifo import fifo_pkg::*;
();

   localparam int WR_HALF = 10;  // 20 ns write clock
   localparam int RD_HALF = 14;  // 28 ns read clock

   localparam logic [31:0] RAND_SEED = 32'h23f1c81d;
   localparam logic [31:0] RAND_TAPS = 32'h80200003;  // x^32+x^22+x^2+x+1

   // Phase codes shared by value with the checker
   localparam logic [2:0] PH_IDLE   = 3'd0;
   localparam logic [2:0] PH_RESET  = 3'd1;
   localparam logic [2:0] PH_RANDOM = 3'd2;
   localparam logic [2:0] PH_FILL   = 3'd3;
   localparam logic [2:0] PH_DRAIN  = 3'd4;
   localparam logic [2:0] PH_CHAOS  = 3'd5;
   localparam logic [2:0] PH_FINAL  = 3'd6;
   localparam logic [2:0] PH_DONE   = 3'd7;

   // Phase lengths in wr_clk cycles
   localparam int LEN_RESET  = 8;
   localparam int LEN_RANDOM = 400;
   localparam int LEN_FILL   = 40;
   localparam int LEN_DRAIN  = 60;
   localparam int LEN_CHAOS  = 400;
   localparam int LEN_FINAL  = 60;
   localparam int RUN_CYCLES = LEN_RESET + LEN_RANDOM + LEN_FILL + LEN_DRAIN +
                               LEN_CHAOS + LEN_FINAL + 6;  // Reset and wind down
   localparam int WATCHDOG_NS = (RUN_CYCLES + 50) * 2 * RD_HALF;  // Slower clock

   logic        wr_clk = 1'b0;
   logic        rd_clk = 1'b0;
   logic        wr_nreset = 1'b0;
   logic        rd_nreset = 1'b0;
   logic        wr_en = 1'b0;
   data_t       wr_din = '0;
   logic        wr_chaosmode = 1'b0;
   logic        wr_full;
   logic        rd_en = 1'b0;
   data_t       rd_dout;
   logic        rd_empty;
   logic [2:0]  phase = PH_IDLE;   // Running test
   logic [31:0] wr_lfsr = RAND_SEED;
   logic [31:0] rd_lfsr = ~RAND_SEED;  // Own stream so clock order never matters
   logic [31:0] rd_draw;
   int          err_count;
   int          check_count;

   always #(WR_HALF) wr_clk = ~wr_clk;
   always #(RD_HALF) rd_clk = ~rd_clk;

   asyncfifo u_dut
   (
      .wr_clk       (wr_clk),
      .wr_nreset    (wr_nreset),
      .wr_din       (wr_din),
      .wr_en        (wr_en),
      .wr_chaosmode (wr_chaosmode),
      .wr_full      (wr_full),
      .rd_clk       (rd_clk),
      .rd_nreset    (rd_nreset),
      .rd_en        (rd_en),
      .rd_dout      (rd_dout),
      .rd_empty     (rd_empty)
   );

   fifo_checker u_check
   (
      .wr_clk      (wr_clk),
      .wr_nreset   (wr_nreset),
      .wr_en       (wr_en),
      .wr_din      (wr_din),
      .wr_full     (wr_full),
      .rd_clk      (rd_clk),
      .rd_nreset   (rd_nreset),
      .rd_en       (rd_en),
      .rd_dout     (rd_dout),
      .rd_empty    (rd_empty),
      .phase       (phase),
      .err_count   (err_count),
      .check_count (check_count)
   );

   // ############################
   // Random source
   // ############################

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ RAND_TAPS) : (s >> 1);  // Galois form
   endfunction

   // n bits from the write stream with one step per bit
   task automatic wr_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v       = {v[30:0], wr_lfsr[0]};
         wr_lfsr = lfsr_step(wr_lfsr);
      end
   endtask

   task automatic rd_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v       = {v[30:0], rd_lfsr[0]};
         rd_lfsr = lfsr_step(rd_lfsr);
      end
   endtask

   // ############################
   // Stimulus
   // ############################

   // Write side traffic for one phase changed on each wr_clk edge
   task automatic run_phase(input logic [2:0] p, input int cycles);
      logic [31:0] bits;
      for (int n = 0; n < cycles; n++)
      begin
         @(posedge wr_clk);
         phase <= p;
         wr_bits(FIFO_DW, bits);
         wr_din <= bits[FIFO_DW-1:0];
         wr_chaosmode <= (p == PH_CHAOS);
         case (p)
            PH_RANDOM:
            begin
               wr_bits(1, bits);
               wr_en <= bits[0];  // Half rate
            end
            PH_FILL:   wr_en <= 1'b1;  // Flat out
            PH_CHAOS:
            begin
               wr_bits(2, bits);
               wr_en <= &bits[1:0];  // Quarter
            end
            default:   wr_en <= 1'b0;
         endcase
      end
   endtask

   // Read enables follow the phase on their own clock
   always @(posedge rd_clk)
   begin
      if (!rd_nreset)
         rd_en <= 1'b0;
      else
         case (phase)
            PH_RANDOM:
            begin
               rd_bits(1, rd_draw);
               rd_en <= rd_draw[0];
            end
            PH_DRAIN, PH_FINAL: rd_en <= 1'b1;   // Keeps reading past empty
            PH_CHAOS:
            begin
               rd_bits(2, rd_draw);
               rd_en <= |rd_draw[1:0];
            end
            default:            rd_en <= 1'b0;
         endcase
   end

   initial
   begin
      repeat (3) @(posedge rd_clk);
      rd_nreset <= 1'b1;
   end

   initial
   begin
      repeat (3) @(posedge wr_clk);
      wr_nreset <= 1'b1;
      wait (rd_nreset);
      run_phase(PH_RESET, LEN_RESET);
      run_phase(PH_RANDOM, LEN_RANDOM);
      run_phase(PH_FILL, LEN_FILL);
      run_phase(PH_DRAIN, LEN_DRAIN);
      run_phase(PH_CHAOS, LEN_CHAOS);
      run_phase(PH_FINAL, LEN_FINAL);
      run_phase(PH_DONE, 3);  // Checker closes the last test
      $display("Summary: %0d checks, %0d errors", check_count, err_count);
      if (err_count == 0 && check_count > 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: fifo_checker.sv
// Watches the FIFO ports on both clocks and compares them with a circular model
// Inputs are sampled on rising edges so stimulus must change by NBAs on those edges
`timescale 1ns/100ps

module fifo_checker import fifo_pkg::*;
(
   input  logic       wr_clk,      // Write clock
   input  logic       wr_nreset,   // Write reset active low
   input  logic       wr_en,
   input  data_t      wr_din,
   input  logic       wr_full,
   input  logic       rd_clk,      // Read clock
   input  logic       rd_nreset,   // Read reset active low
   input  logic       rd_en,
   input  data_t      rd_dout,
   input  logic       rd_empty,
   input  logic [2:0] phase,       // Running test set by the testbench
   output int         err_count,   // Errors over the whole run
   output int         check_count  // Compares over the whole run
);

   // Phase codes matching the testbench
   localparam logic [2:0] PH_IDLE  = 3'd0;
   localparam logic [2:0] PH_RESET = 3'd1;
   localparam logic [2:0] PH_FILL  = 3'd3;
   localparam logic [2:0] PH_DRAIN = 3'd4;
   localparam logic [2:0] PH_CHAOS = 3'd5;
   localparam logic [2:0] PH_FINAL = 3'd6;

   localparam int MODEL_SIZE = 64;  // Far above FIFO_DEPTH
   localparam int SETTLE     = 10;  // Wr cycles until a late read has reached wr_full

   data_t      model_mem [MODEL_SIZE];  // Reference queue storage
   int         pushes = 0;              // Accepted writes
   int         pops = 0;                // Taken reads
   int         held_wr;                 // Model level seen on wr_clk
   int         held_rd;                 // Model level seen on rd_clk
   int         wr_errs = 0;
   int         rd_errs = 0;
   int         wr_checks = 0;
   int         rd_checks = 0;
   int         drain_pops = 0;          // Reads taken in the drain test
   logic [2:0] last_phase = PH_IDLE;
   int         phase_cycles = 0;
   int         errs_at_start = 0;
   int         checks_at_start = 0;
   logic       full_seen = 1'b0;        // Overflow test reached full
   logic       full_fell = 1'b0;
   logic       chaos_seen = 1'b0;       // Full seen below depth in chaos test

   assign err_count   = wr_errs + rd_errs;
   assign check_count = wr_checks + rd_checks;

   function automatic string phase_name(input logic [2:0] p);
      case (p)
         PH_RESET: phase_name = "reset state";
         3'd2:     phase_name = "random traffic";
         PH_FILL:  phase_name = "overflow fill";
         PH_DRAIN: phase_name = "drain and underflow";
         PH_CHAOS: phase_name = "chaos mode";
         default:  phase_name = "final drain";
      endcase
   endfunction

   // One write side compare that prints on mismatch
   task automatic expect_wr(input string sig, input logic [31:0] exp, input logic [31:0] act);
      wr_checks++;
      if (act !== exp)
      begin
         $display("CHECK FAILED %s expected %0h actual %0h at %0t", sig, exp, act, $time);
         wr_errs++;
      end
   endtask

   // ############################
   // End of test checks
   // ############################

   task automatic close_phase(input logic [2:0] p);
      int errs;
      case (p)
         PH_FILL:
         begin
            expect_wr("wr_full seen high", 32'd1, 32'(full_seen));
            expect_wr("model level", FIFO_DEPTH, held_wr);  // Exactly full
         end
         PH_DRAIN:
         begin
            expect_wr("drain read count", FIFO_DEPTH, drain_pops);
            expect_wr("model level", 32'd0, held_wr);
            expect_wr("rd_empty", 32'd1, 32'(rd_empty));
         end
         PH_CHAOS:
         begin
            wr_checks++;
            if (!chaos_seen)
            begin
               $display("ERROR chaos mode never raised wr_full below depth");
               wr_errs++;
            end
         end
         PH_FINAL:
         begin
            expect_wr("model level", 32'd0, held_wr);
            expect_wr("rd_empty", 32'd1, 32'(rd_empty));
         end
         default: ;
      endcase
      errs = wr_errs + rd_errs - errs_at_start;
      $display("Test %0d %s: %s, %0d checks, %0d errors", p, phase_name(p),
               (errs == 0) ? "ok" : "FAIL", wr_checks + rd_checks - checks_at_start, errs);
   endtask

   // ############################
   // Write side
   // ############################

   always @(posedge wr_clk)
   begin
      if (wr_nreset)
      begin
         held_wr = pushes - pops;
         if (phase != last_phase)
         begin
            if (last_phase != PH_IDLE)
               close_phase(last_phase);  // Prints the finished test
            last_phase      = phase;
            phase_cycles    = 0;
            errs_at_start   = wr_errs + rd_errs;
            checks_at_start = wr_checks + rd_checks;
         end
         else
            phase_cycles++;

         case (phase)
            PH_RESET:
            begin
               expect_wr("wr_full", 32'd0, 32'(wr_full));
               expect_wr("rd_empty", 32'd1, 32'(rd_empty));
            end
            PH_FILL:
            begin
               if (phase_cycles >= SETTLE && wr_full)
                  full_seen = 1'b1;
               else if (full_seen && !full_fell)
               begin
                  $display("ERROR wr_full fell while reads were stopped at %0t", $time);
                  full_fell = 1'b1;  // Report once
                  wr_errs++;
               end
            end
            PH_CHAOS:
               if (wr_full && held_wr < FIFO_DEPTH)
                  chaos_seen = 1'b1;
            default: ;
         endcase

         // Accepted write enters the model
         if (wr_en && !wr_full)
         begin
            wr_checks++;
            if (held_wr >= FIFO_DEPTH)
            begin
               $display("ERROR write accepted with %0d words already held at %0t",
                        held_wr, $time);
               wr_errs++;
            end
            model_mem[pushes % MODEL_SIZE] = wr_din;
            pushes <= pushes + 1;  // Seen by the read side from the next step
         end
      end
   end

   // ############################
   // Read side
   // ############################

   always @(posedge rd_clk)
   begin
      if (rd_nreset)
      begin
         held_rd = pushes - pops;
         rd_checks++;
         if (!rd_empty && held_rd == 0)
         begin
            $display("ERROR rd_empty low while the model is empty at %0t", $time);
            rd_errs++;
         end
         else if (rd_en && !rd_empty)  // Taken read whose head must match
         begin
            if (rd_dout !== model_mem[pops % MODEL_SIZE])
            begin
               $display("CHECK FAILED rd_dout expected %0h actual %0h at %0t",
                        model_mem[pops % MODEL_SIZE], rd_dout, $time);
               rd_errs++;
            end
            pops <= pops + 1;
            if (phase == PH_DRAIN)
               drain_pops++;
         end
      end
   end

endmodule

// File: asyncfifo.sv
// Dual clock FIFO with first word fall through read and pessimistic flags
// Writes while wr_full is high are dropped and the source must watch wr_full
`timescale 1ns/100ps

module asyncfifo import fifo_pkg::*, cdc_pkg::*;
(
   // Write side
   input  logic  wr_clk,        // Write clock
   input  logic  wr_nreset,     // Write reset, async low
   input  data_t wr_din,        // Word to write
   input  logic  wr_en,         // Write request
   input  logic  wr_chaosmode,  // Random full when high
   output logic  wr_full,       // Registered full flag
   // Read side
   input  logic  rd_clk,        // Read clock
   input  logic  rd_nreset,     // Read reset, async low
   input  logic  rd_en,         // Read request
   output data_t rd_dout,       // Head word, valid while not empty
   output logic  rd_empty       // Registered empty flag
);

   // Write domain
   logic  wr_accept;     // Write taken this cycle
   ptr_t  wr_bin;        // Write binary pointer
   ptr_t  wr_gray;       // Write Gray pointer, crosses to read side
   addr_t wr_addr;       // Write slot
   ptr_t  rd_gray_sync;  // Read Gray pointer seen on wr_clk
   ptr_t  rd_bin_sync;   // Same, back in binary
   ptr_t  wr_used;       // Entries held, as seen by the writer
   logic  chaos_full;    // LFSR full request

   // Read domain
   logic  rd_take;       // Read taken this cycle
   ptr_t  rd_gray;       // Read Gray pointer, crosses to write side
   ptr_t  rd_gray_nxt;   // Read Gray pointer after this cycle
   addr_t rd_addr;       // Head slot
   ptr_t  wr_gray_sync;  // Write Gray pointer seen on rd_clk

   // ############################
   // Write side
   // ############################

   assign wr_accept = wr_en & ~wr_full;  // Full blocks the write

   fifo_ptr u_wr_ptr
   (
      .clk      (wr_clk),
      .nreset   (wr_nreset),
      .advance  (wr_accept),
      .bin_ptr  (wr_bin),
      .gray_ptr (wr_gray),
      .gray_nxt (),           // Not needed for full
      .mem_addr (wr_addr)
   );

   // Gray to binary, MSB down
   always_comb
   begin
      rd_bin_sync[FIFO_AW] = rd_gray_sync[FIFO_AW];
      for (int i = FIFO_AW - 1; i >= 0; i--)
      begin
         rd_bin_sync[i] = rd_bin_sync[i+1] ^ rd_gray_sync[i];
      end
   end

   // Modulo difference, never above FIFO_DEPTH
   assign wr_used = wr_bin - rd_bin_sync;

   chaos_lfsr u_chaos
   (
      .wr_clk     (wr_clk),
      .wr_nreset  (wr_nreset),
      .chaos_full (chaos_full)
   );

   // Full when this write fills the last slot, or on a chaos request
   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
      begin
         wr_full <= 1'b0;
      end
      else
      begin
         wr_full <= (chaos_full & wr_chaosmode) |
                    ((wr_used + ptr_t'(wr_accept)) == ptr_t'(FIFO_DEPTH));
      end
   end

   // Write pointer into the read domain
   for (genvar i = 0; i < FIFO_PW; i++)
   begin : g_wr2rd
      drsync u_sync
      (
         .clk    (rd_clk),
         .nreset (rd_nreset),
         .in     (wr_gray[i]),
         .out    (wr_gray_sync[i])
      );
   end

   // ############################
   // Read side
   // ############################

   assign rd_take = rd_en & ~rd_empty;  // Reads while empty do nothing

   fifo_ptr u_rd_ptr
   (
      .clk      (rd_clk),
      .nreset   (rd_nreset),
      .advance  (rd_take),
      .bin_ptr  (),             // Occupancy is only kept on the write side
      .gray_ptr (rd_gray),
      .gray_nxt (rd_gray_nxt),
      .mem_addr (rd_addr)
   );

   // Empty when the next read position catches the writer
   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
      begin
         rd_empty <= 1'b1;
      end
      else
      begin
         rd_empty <= (rd_gray_nxt == wr_gray_sync);
      end
   end

   // Read pointer into the write domain
   for (genvar i = 0; i < FIFO_PW; i++)
   begin : g_rd2wr
      drsync u_sync
      (
         .clk    (wr_clk),
         .nreset (wr_nreset),
         .in     (rd_gray[i]),
         .out    (rd_gray_sync[i])
      );
   end

   // ############################
   // Storage
   // ############################

   fifo_ram u_ram
   (
      .wr_clk  (wr_clk),
      .wr_we   (wr_accept),
      .wr_addr (wr_addr),
      .wr_data (wr_din),
      .rd_addr (rd_addr),
      .rd_data (rd_dout)    // Head word falls through
   );

endmodule

// File: chaos_lfsr.sv
// Free running Galois LFSR in the write domain used to fake a full FIFO
// Runs regardless of chaos mode and the top gates its request
`timescale 1ns/100ps

module chaos_lfsr import cdc_pkg::*;
(
   input  logic wr_clk,     // Write clock
   input  logic wr_nreset,  // Write reset, async low
   output logic chaos_full  // Pseudo random full request
);

   chaos_t lfsr_q;    // LFSR state
   chaos_t lfsr_nxt;  // State after one step

   // ############################
   // Galois step
   // ############################

   // Shift right, fold taps in when a one falls out
   always_comb
   begin
      lfsr_nxt = lfsr_q >> 1;
      if (lfsr_q[0])
      begin
         lfsr_nxt = lfsr_nxt ^ CHAOS_TAPS;
      end
   end

   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
      begin
         lfsr_q <= CHAOS_SEED;  // Nonzero start
      end
      else
      begin
         lfsr_q <= lfsr_nxt;  // Stepped every cycle
      end
   end

   // Low bit gives roughly half the cycles with an irregular pattern
   assign chaos_full = lfsr_q[0];

endmodule

// File: fifo_ram.sv
// Storage for the FIFO with no reset on the array
// Read is combinational so the head word shows without a clock
`timescale 1ns/100ps

module fifo_ram import fifo_pkg::*;
(
   input  logic  wr_clk,   // Write clock
   input  logic  wr_we,    // Write strobe, already qualified by full
   input  addr_t wr_addr,  // Write slot
   input  data_t wr_data,  // Word to store
   input  addr_t rd_addr,  // Read slot, from the read clock domain
   output data_t rd_data   // Word at rd_addr
);

   data_t mem [FIFO_DEPTH];  // Storage words

   // ############################
   // Write port
   // ############################

   always_ff @(posedge wr_clk)
   begin
      if (wr_we)
      begin
         mem[wr_addr] <= wr_data;  // Indices stay below FIFO_DEPTH
      end
   end

   // ############################
   // Read port
   // ############################

   // Slot is stable while rd_empty is low
   // The write side never touches a slot the read side still holds
   assign rd_data = mem[rd_addr];

endmodule

// File: fifo_ptr.sv
// Pointer keeper for one side of the FIFO, clocked by that side's clock
// advance must already be qualified by the side's flag
`timescale 1ns/100ps

module fifo_ptr import fifo_pkg::*;
(
   input  logic  clk,       // Side clock
   input  logic  nreset,    // Side reset, async low
   input  logic  advance,   // Accepted write or taken read
   output ptr_t  bin_ptr,   // Binary pointer with wrap bit
   output ptr_t  gray_ptr,  // Registered Gray pointer
   output ptr_t  gray_nxt,  // Gray of next binary value
   output addr_t mem_addr   // Memory index, wraps at FIFO_DEPTH
);

   ptr_t  bin_q;     // Binary count of accepted ops
   ptr_t  bin_nxt;   // Binary count after this cycle
   ptr_t  gray_q;    // Gray copy for crossing
   addr_t addr_q;    // Current memory slot
   ptr_t  addr_inc;  // Slot plus advance, one bit wider

   // ############################
   // Next values
   // ############################

   // Binary pointer wraps at power of two on its own
   assign bin_nxt = bin_q + ptr_t'(advance);

   // Widened so DEPTH itself is representable for the wrap test
   assign addr_inc = ptr_t'(addr_q) + ptr_t'(advance);

   // Binary to Gray
   assign gray_nxt = bin_nxt ^ (bin_nxt >> 1);

   // ############################
   // Registers
   // ############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         bin_q  <= '0;
         gray_q <= '0;  // Gray of zero is zero
         addr_q <= '0;
      end
      else
      begin
         bin_q  <= bin_nxt;
         gray_q <= gray_nxt;  // Single bit change per advance

         // Slot index wraps at depth, not at the power of two
         if (addr_inc == ptr_t'(FIFO_DEPTH))
         begin
            addr_q <= '0;
         end
         else
         begin
            addr_q <= addr_inc[FIFO_AW-1:0];
         end
      end
   end

   // ############################
   // Outputs
   // ############################

   assign bin_ptr  = bin_q;
   assign gray_ptr = gray_q;   // Only this one may cross domains
   assign mem_addr = addr_q;

   // bin_q and addr_q move together
   // bin_q counts modulo 2**FIFO_PW while addr_q counts modulo FIFO_DEPTH
   // Occupancy comes from bin_q, storage slots come from addr_q

endmodule

// File: drsync.sv
// One bit synchronizer of SYNC_STAGES flops, needs SYNC_STAGES of 2 or more
// Input must be glitch free and change at most once per destination edge
`timescale 1ns/100ps

module drsync import cdc_pkg::*;
(
   input  logic clk,     // Destination clock
   input  logic nreset,  // Destination reset, async low
   input  logic in,      // Bit from the source domain
   output logic out      // Synchronized bit
);

   logic [SYNC_STAGES-1:0] sync_q;  // Shift chain, bit 0 samples first

   // Only path between the two clock domains
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         sync_q <= '0;  // Cleared to zero
      end
      else
      begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], in};
      end
   end

   // Last stage is the settled value
   assign out = sync_q[SYNC_STAGES-1];

endmodule

// File: cdc_pkg.sv
// Synchronizer length and chaos LFSR constants for the clock crossing logic
// CHAOS_SEED must stay nonzero or the LFSR locks up
package cdc_pkg;

   localparam int SYNC_STAGES = 2;  // Flops per synchronized bit, 2 or more

   // ############################
   // Chaos source
   // ############################

   localparam int CHAOS_W = 16;  // LFSR width

   typedef logic [CHAOS_W-1:0] chaos_t;  // LFSR state

   // Maximal length polynomial x^16 + x^14 + x^13 + x^11 + 1
   localparam chaos_t CHAOS_TAPS = 16'hB400;
   localparam chaos_t CHAOS_SEED = 16'hACE1;  // Reset value

endpackage

// File: fifo_pkg.sv
// Depth need not be a power of two since the memory index wraps at FIFO_DEPTH
// Pointers carry one extra bit so that full and empty can be told apart
package fifo_pkg;

   // ############################
   // Word and storage size
   // ############################

   localparam int FIFO_DW    = 16;  // Data word width
   localparam int FIFO_DEPTH = 6;   // Entries in storage

   // Index width, never below 1 bit
   localparam int FIFO_AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

   // Pointer width with the wrap bit on top
   localparam int FIFO_PW = FIFO_AW + 1;

   // ############################
   // Typedefs
   // ############################

   typedef logic [FIFO_DW-1:0] data_t;  // One data word
   typedef logic [FIFO_PW-1:0] ptr_t;   // Binary or Gray pointer
   typedef logic [FIFO_AW-1:0] addr_t;  // Memory index

   // Binary pointers wrap at 2**FIFO_PW
   // Occupancy never exceeds FIFO_DEPTH so modulo subtraction stays exact

endpackage
